/* design/accelPkg.sv */
// Accelerator shell types: host receive and transmit messages, register map
`default_nettype none

package accelPkg;

  `include "accel_settings.svh"

  // Message kind on the receive channel
  typedef enum logic
  {
    regWrite = 1'b0,
    regRead  = 1'b1
  } rxKind_e;

  // Register map, same for every accelerator
  typedef enum logic [7:0]
  {
    regOperate = 8'd0,  // Add or feed on write, result on read
    regControl = 8'd1   // Clear or reseed on write
  } regAddr_e;

  // ========================================================================
  // Receive payload, decoded as write or read
  // ========================================================================
  typedef struct packed
  {
    logic [7:0]  addr;
    logic [31:0] data;
  } rxWrView_t;

  typedef struct packed
  {
    logic [7:0]  addr;  // Same bits as the write address
    logic [7:0]  tag;   // Echoed back in the response
    logic [23:0] pad;
  } rxRdView_t;

  typedef union packed
  {
    rxWrView_t wr;
    rxRdView_t rd;
  } rxPayload_u;

  // Host to accelerator, 44 bits
  typedef struct packed
  {
    logic                    valid;
    rxKind_e                 kind;
    logic [`ACCEL_IDX_W-1:0] accelIdx;
    rxPayload_u              payload;
  } rxMsg_t;

  // Read response toward the host, 43 bits
  typedef struct packed
  {
    logic                    valid;
    logic [`ACCEL_IDX_W-1:0] accelIdx;
    logic [7:0]              tag;
    logic [31:0]             data;
  } txMsg_t;

endpackage

`default_nettype wire

/* design/accelShell.sv */
// Accelerator shell top: registers host inputs, muxes four sub-accelerators
`timescale 1ns/1ps
`default_nettype none

`include "accel_settings.svh"

module accelShell
  import accelPkg::*;
(
  input  logic   pClk,
  input  logic   rstN,       // Async, active low
  input  logic   softReset,  // Sync, active high, from host
  input  rxMsg_t rxIn,       // Host receive channel
  output txMsg_t txOut       // Host transmit channel
);

  // ========================================================================
  // Input registers, one stage ahead of the multiplexer
  // ========================================================================
  rxMsg_t rxInQ;
  logic   softResetQ;

  always_ff @(posedge pClk or negedge rstN)
  begin
    if (!rstN)
    begin
      rxInQ      <= '0;
      softResetQ <= 1'b0;
    end
    else
    begin
      rxInQ      <= rxIn;
      softResetQ <= softReset;
    end
  end

  // ========================================================================
  // Port multiplexer
  // ========================================================================
  rxMsg_t portRx    [`ACCEL_COUNT-1:0];
  txMsg_t portTx    [`ACCEL_COUNT-1:0];
  logic   portReset [`ACCEL_COUNT-1:0];
  logic   portGrant [`ACCEL_COUNT-1:0];

  portMux portMuxInst (
    .pClk      (pClk),
    .rstN      (rstN),
    .softReset (softResetQ),
    .upRx      (rxInQ),
    .upTx      (txOut),      // Registered inside the mux
    .portRx    (portRx),
    .portReset (portReset),
    .portTx    (portTx),
    .portGrant (portGrant)
  );

  // Ports 0 and 1 are running sums, 2 and 3 fold-hashes
  sumAccel sumAccel0 (
    .pClk(pClk), .rstN(rstN), .portReset(portReset[0]),
    .portRx(portRx[0]), .portTx(portTx[0]), .portGrant(portGrant[0])
  );

  sumAccel sumAccel1 (
    .pClk(pClk), .rstN(rstN), .portReset(portReset[1]),
    .portRx(portRx[1]), .portTx(portTx[1]), .portGrant(portGrant[1])
  );

  foldHashAccel foldHashAccel2 (
    .pClk(pClk), .rstN(rstN), .portReset(portReset[2]),
    .portRx(portRx[2]), .portTx(portTx[2]), .portGrant(portGrant[2])
  );

  foldHashAccel foldHashAccel3 (
    .pClk(pClk), .rstN(rstN), .portReset(portReset[3]),
    .portRx(portRx[3]), .portTx(portTx[3]), .portGrant(portGrant[3])
  );

endmodule

`default_nettype wire

/* design/accel_settings.svh */
// Accelerator shell settings: port count, index width and fold-hash start value
`ifndef ACCEL_SETTINGS_SVH
`define ACCEL_SETTINGS_SVH

// ==========================================================================
// Port layout
// ==========================================================================

// Sub-accelerators behind the port multiplexer
`define ACCEL_COUNT 4

// Index carried in every host message, log2 of the port count
`define ACCEL_IDX_W 2

// ==========================================================================
// Fold-hash
// ==========================================================================

`define HASH_SEED 32'h6A09E667  // Start value after any reset or reseed

`endif

/* design/foldHashAccel.sv */
// Fold-hash accelerator: rotate-left-5 and xor over fed words, with reseed
`timescale 1ns/1ps
`default_nettype none

`include "accel_settings.svh"

module foldHashAccel
  import accelPkg::*;
(
  input  logic   pClk,
  input  logic   rstN,
  input  logic   portReset,  // Soft reset from the mux
  input  rxMsg_t portRx,
  output txMsg_t portTx,     // Held until portGrant
  input  logic   portGrant
);

  logic [31:0] hashState;
  logic [31:0] hashNext;

  // ========================================================================
  // Hash state
  // ========================================================================

  // One fold step
  assign hashNext = {hashState[26:0], hashState[31:27]} ^ portRx.payload.wr.data;

  always_ff @(posedge pClk or negedge rstN)
  begin
    if (!rstN)
      hashState <= `HASH_SEED;
    else if (portReset)
      hashState <= `HASH_SEED;
    else if (portRx.valid && portRx.kind == regWrite)
    begin
      case (portRx.payload.wr.addr)
        regOperate: hashState <= hashNext;    // Feed a word
        regControl: hashState <= `HASH_SEED;  // Reseed, data ignored
        default:    ;
      endcase
    end
  end

  // ========================================================================
  // Response slot
  // ========================================================================
  always_ff @(posedge pClk or negedge rstN)
  begin
    if (!rstN)
      portTx <= '0;
    else if (portReset)
      portTx <= '0;
    else if (portRx.valid && portRx.kind == regRead)
    begin
      portTx.valid    <= 1'b1;
      portTx.accelIdx <= portRx.accelIdx;        // Own index, as addressed
      portTx.tag      <= portRx.payload.rd.tag;
      portTx.data     <= (portRx.payload.rd.addr == regOperate) ? hashState : '0;
    end
    else if (portGrant)
      portTx.valid <= 1'b0;
  end

endmodule

`default_nettype wire

/* design/portMux.sv */
// Port multiplexer: routes host messages by index, fans out reset, merges responses
`timescale 1ns/1ps
`default_nettype none

`include "accel_settings.svh"

module portMux
  import accelPkg::*;
(
  input  logic   pClk,
  input  logic   rstN,
  input  logic   softReset,                      // Already registered by the shell
  input  rxMsg_t upRx,
  output txMsg_t upTx,
  output rxMsg_t portRx    [`ACCEL_COUNT-1:0],
  output logic   portReset [`ACCEL_COUNT-1:0],
  input  txMsg_t portTx    [`ACCEL_COUNT-1:0],   // Held response slots
  output logic   portGrant [`ACCEL_COUNT-1:0]    // One-cycle pulse per granted slot
);

  logic                    resetQ;
  logic [`ACCEL_IDX_W-1:0] lastPtr;    // Port granted most recently
  logic [`ACCEL_IDX_W-1:0] grantIdx;
  logic                    grantHit;

  // ========================================================================
  // Receive routing and reset fan-out
  // ========================================================================
  always_ff @(posedge pClk or negedge rstN)
  begin
    if (!rstN)
      resetQ <= 1'b0;
    else
      resetQ <= softReset;
  end

  for (genvar i = 0; i < `ACCEL_COUNT; i++)
  begin : genPort
    always_ff @(posedge pClk or negedge rstN)
    begin
      if (!rstN)
        portRx[i] <= '0;
      else
      begin
        portRx[i]       <= upRx;  // Payload copied to every port
        portRx[i].valid <= upRx.valid && (upRx.accelIdx == `ACCEL_IDX_W'(i));
      end
    end

    assign portReset[i] = resetQ;
    assign portGrant[i] = grantHit && (grantIdx == `ACCEL_IDX_W'(i));
  end

  // ========================================================================
  // Round-robin response arbitration
  // ========================================================================
  always_comb
  begin
    int cand;
    grantIdx = '0;
    grantHit = 1'b0;
    // Search starts one past the last winner, so the last winner is checked last
    for (int k = 1; k <= `ACCEL_COUNT; k++)
    begin
      cand = (int'(lastPtr) + k) % `ACCEL_COUNT;
      if (!grantHit && portTx[cand].valid)
      begin
        grantHit = 1'b1;
        grantIdx = `ACCEL_IDX_W'(cand);
      end
    end
    if (resetQ)
      grantHit = 1'b0;  // Slots are being flushed
  end

  always_ff @(posedge pClk or negedge rstN)
  begin
    if (!rstN)
    begin
      upTx    <= '0;
      lastPtr <= `ACCEL_IDX_W'(`ACCEL_COUNT - 1);  // Port 0 wins first
    end
    else if (grantHit)
    begin
      upTx    <= portTx[grantIdx];  // Registered in the same step as the grant
      lastPtr <= grantIdx;
    end
    else
      upTx <= '0;
  end

endmodule

`default_nettype wire

/* design/sumAccel.sv */
// Running-sum accelerator: add, clear and read of a 32-bit accumulator
`timescale 1ns/1ps
`default_nettype none

module sumAccel
  import accelPkg::*;
(
  input  logic   pClk,
  input  logic   rstN,
  input  logic   portReset,  // Soft reset from the mux
  input  rxMsg_t portRx,
  output txMsg_t portTx,     // Held until portGrant
  input  logic   portGrant
);

  logic [31:0] accum;

  // ========================================================================
  // Accumulator
  // ========================================================================
  always_ff @(posedge pClk or negedge rstN)
  begin
    if (!rstN)
      accum <= '0;
    else if (portReset)
      accum <= '0;
    else if (portRx.valid && portRx.kind == regWrite)
    begin
      case (portRx.payload.wr.addr)
        regOperate: accum <= accum + portRx.payload.wr.data;  // Wraps mod 2^32
        regControl: accum <= '0;
        default:    ;                                         // Unmapped, ignored
      endcase
    end
  end

  // Response slot
  always_ff @(posedge pClk or negedge rstN)
  begin
    if (!rstN)
      portTx <= '0;
    else if (portReset)
      portTx <= '0;
    else if (portRx.valid && portRx.kind == regRead)
    begin
      portTx.valid    <= 1'b1;
      portTx.accelIdx <= portRx.accelIdx;
      portTx.tag      <= portRx.payload.rd.tag;
      // Only the result register reads back
      portTx.data     <= (portRx.payload.rd.addr == regOperate) ? accum : '0;
    end
    else if (portGrant)
      portTx.valid <= 1'b0;  // Taken by the mux this cycle
  end

endmodule

`default_nettype wire

/* dv/accelShellTb.sv */
// Testbench for the accelerator shell: file-driven host traffic checked against a model
`timescale 1ns/1ps
`default_nettype none

`include "accel_settings.svh"

module accelShellTb
  import accelPkg::*;
();

  logic   pClk;
  logic   rstN;
  logic   softReset;
  rxMsg_t rxIn;
  txMsg_t txOut;

  logic [31:0] modelVal [`ACCEL_COUNT];  // Sums on ports 0 and 1, hashes on 2 and 3
  int          fd;

  accelShell accelShell_i (
    .pClk      (pClk),
    .rstN      (rstN),
    .softReset (softReset),
    .rxIn      (rxIn),
    .txOut     (txOut)
  );

  initial
  begin
    pClk = 1'b0;
    forever #4 pClk = ~pClk;  // 8 ns period
  end

  // ==========================================================================
  // Model and message builders
  // ==========================================================================
  function automatic logic [31:0] foldStep(input logic [31:0] s, input logic [31:0] d);
    return {s[26:0], s[31:27]} ^ d;  // Rotate left by 5, then xor
  endfunction

  function automatic void modelReset();
    for (int i = 0; i < `ACCEL_COUNT; i++)
      modelVal[i] = (i < 2) ? 32'd0 : `HASH_SEED;
  endfunction

  function automatic void modelWrite(input logic [`ACCEL_IDX_W-1:0] idx,
                                     input logic [7:0] addr, input logic [31:0] data);
    if (addr == regOperate)
      modelVal[idx] = (int'(idx) < 2) ? modelVal[idx] + data : foldStep(modelVal[idx], data);
    else if (addr == regControl)
      modelVal[idx] = (int'(idx) < 2) ? 32'd0 : `HASH_SEED;  // Clear or reseed
  endfunction

  function automatic rxMsg_t makeWrite(input logic [`ACCEL_IDX_W-1:0] idx,
                                       input logic [7:0] addr, input logic [31:0] data);
    rxMsg_t m;
    m                 = '0;
    m.valid           = 1'b1;
    m.kind            = regWrite;
    m.accelIdx        = idx;
    m.payload.wr.addr = addr;
    m.payload.wr.data = data;
    return m;
  endfunction

  function automatic rxMsg_t makeRead(input logic [`ACCEL_IDX_W-1:0] idx,
                                      input logic [7:0] tag);
    rxMsg_t m;
    m                 = '0;
    m.valid           = 1'b1;
    m.kind            = regRead;
    m.accelIdx        = idx;
    m.payload.rd.addr = regOperate;  // Result register
    m.payload.rd.tag  = tag;
    return m;
  endfunction

  function automatic txMsg_t expectRsp(input logic [`ACCEL_IDX_W-1:0] idx,
                                       input logic [7:0] tag);
    txMsg_t r;
    r = '{1'b1, idx, tag, modelVal[idx]};
    return r;
  endfunction

  // ==========================================================================
  // Stepping, checks and operations
  // ==========================================================================

  // Lands just after the rising edge, where inputs change and outputs are stable
  task automatic stepCycle();
    @(posedge pClk);
    #1;
  endtask

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic checkRsp(input string name, input txMsg_t exp, input txMsg_t act);
    string actTxt;
    actTxt = $sformatf("valid %b idx %0d tag %h data %h",
                       act.valid, act.accelIdx, act.tag, act.data);
    if (act !== exp)
      abortRun($sformatf("ERR %s expected idx %0d tag %h data %h, actual %s",
                         name, exp.accelIdx, exp.tag, exp.data, actTxt));
  endtask

  task automatic checkIdle(input string name, input logic exp, input logic act);
    if (act !== exp)
      abortRun($sformatf("ERR %s expected txOut.valid %b actual %b", name, exp, act));
  endtask

  task automatic driveMsg(input rxMsg_t m);
    rxIn = m;
    stepCycle();
    rxIn = '0;  // One-cycle strobe
  endtask

  task automatic waitRsp(input string name, output txMsg_t rsp);
    int n;
    n = 0;
    while (!txOut.valid && n < 50)
    begin
      stepCycle();
      n++;
    end
    if (!txOut.valid)
      abortRun($sformatf("Response to %s never arrived within 50 cycles", name));
    else
      rsp = txOut;
  endtask

  task automatic doRead(input string name, input logic [`ACCEL_IDX_W-1:0] idx,
                        input logic [7:0] tag, input logic [31:0] fileExp);
    txMsg_t exp;
    txMsg_t fromFile;
    txMsg_t rsp;
    exp      = expectRsp(idx, tag);
    fromFile = '{1'b1, idx, tag, fileExp};
    checkRsp({name, " model"}, fromFile, exp);  // Model against the vector file
    driveMsg(makeRead(idx, tag));
    waitRsp(name, rsp);
    checkRsp(name, exp, rsp);
  endtask

  // Reads every port on back-to-back cycles and accepts the responses in any order
  task automatic doBurst(input string name, input logic [7:0] tagBase);
    logic   seen [`ACCEL_COUNT];
    txMsg_t rsp;
    int     sent;
    int     got;
    int     waited;
    sent   = 0;
    got    = 0;
    waited = 0;
    for (int i = 0; i < `ACCEL_COUNT; i++)
      seen[i] = 1'b0;
    while (got < `ACCEL_COUNT)
    begin
      if (sent < `ACCEL_COUNT)
      begin
        rxIn = makeRead(`ACCEL_IDX_W'(sent), 8'(int'(tagBase) + sent));
        sent++;
      end
      else
        rxIn = '0;
      stepCycle();
      waited++;
      if (waited > 50 + `ACCEL_COUNT)
        abortRun($sformatf("%s: only %0d of %0d responses arrived", name, got, `ACCEL_COUNT));
      else if (txOut.valid)
      begin
        rsp = txOut;
        if (seen[rsp.accelIdx])
          abortRun($sformatf("%s: second response from port %0d", name, rsp.accelIdx));
        else
        begin
          seen[rsp.accelIdx] = 1'b1;
          got++;
          checkRsp($sformatf("%s port %0d", name, rsp.accelIdx),
                   expectRsp(rsp.accelIdx, 8'(int'(tagBase) + int'(rsp.accelIdx))), rsp);
        end
      end
    end
    rxIn = '0;
  endtask

  task automatic doSoftReset(input string name);
    softReset = 1'b1;
    stepCycle();
    softReset = 1'b0;
    modelReset();
    repeat (2)  // Mux stage, then the accelerators reload
    begin
      stepCycle();
      checkIdle(name, 1'b0, txOut.valid);
    end
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial
  begin
    string                   opWord;
    string                   name;
    logic [`ACCEL_IDX_W-1:0] idxF;
    logic [7:0]              argF;   // Address for writes, tag for reads
    logic [31:0]             dataF;
    logic [31:0]             expF;
    int                      code;
    int                      ch;
    int                      step;

    rstN      = 1'b0;
    softReset = 1'b0;
    rxIn      = '0;
    step      = 0;
    modelReset();
    repeat (10) @(posedge pClk);
    #1;
    rstN = 1'b1;

    for (int i = 0; i < 20; i++)
    begin
      stepCycle();
      checkIdle("idle after reset", 1'b0, txOut.valid);
    end

    fd = $fopen("dv/accel_input.txt", "r");
    if (fd == 0)
      abortRun("Cannot open stimulus file dv/accel_input.txt");
    code = $fscanf(fd, "%s", opWord);
    while (code == 1)
    begin
      if (opWord == "#")
      begin
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1)  // Rest of a comment line
          ch = $fgetc(fd);
      end
      else
      begin
        code = $fscanf(fd, "%h %h %h %h", idxF, argF, dataF, expF);
        step++;
        name = $sformatf("step %0d %s", step, opWord);
        if (code != 4)
          abortRun($sformatf("Stimulus %s has fewer than four numbers", name));
        else if (opWord == "write")
        begin
          driveMsg(makeWrite(idxF, argF, dataF));
          modelWrite(idxF, argF, dataF);
        end
        else if (opWord == "read")
          doRead(name, idxF, argF, expF);
        else if (opWord == "burst")
          doBurst(name, argF);
        else if (opWord == "softreset")
          doSoftReset(name);
        else
          abortRun($sformatf("Unknown opcode in %s", name));
      end
      code = $fscanf(fd, "%s", opWord);
    end
    $fclose(fd);

    if (accelShell_i.portMuxInst.propsInst.failCount == 0)
    begin
      $display("No errors");
      $finish;
    end
    else
    begin
      $display("Errors found");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

/* dv/accelShell_props.sv */
// Bound checks on the port multiplexer: grant rules, receive routing and reset state
`timescale 1ns/1ps
`default_nettype none

`include "accel_settings.svh"

module accelShell_props
  import accelPkg::*;
(
  input logic   pClk,
  input logic   rstN,
  input rxMsg_t portRx    [`ACCEL_COUNT-1:0],
  input txMsg_t portTx    [`ACCEL_COUNT-1:0],
  input logic   portGrant [`ACCEL_COUNT-1:0],
  input txMsg_t upTx
);

  logic [`ACCEL_COUNT-1:0] grantVec;   // Grants flattened per port
  logic [`ACCEL_COUNT-1:0] slotVec;    // Held response slots
  logic [`ACCEL_COUNT-1:0] rxVec;      // Routed receive strobes
  int                      failCount = 0;  // Failed assertions so far

  always_comb
  begin
    for (int i = 0; i < `ACCEL_COUNT; i++)
    begin
      grantVec[i] = portGrant[i];
      slotVec[i]  = portTx[i].valid;
      rxVec[i]    = portRx[i].valid;
    end
  end

  // ==========================================================================
  // Arbitration and routing
  // ==========================================================================
  oneGrant: assert property (@(posedge pClk) disable iff (!rstN) $onehot0(grantVec))
    else
    begin
      failCount++;
      $error("More than one port granted in a cycle");
    end

  grantToFull: assert property (@(posedge pClk) disable iff (!rstN) (grantVec & ~slotVec) == '0)
    else
    begin
      failCount++;
      $error("Grant to a port with an empty slot");
    end

  oneRoute: assert property (@(posedge pClk) disable iff (!rstN) $onehot0(rxVec))
    else
    begin
      failCount++;
      $error("Receive message routed to several ports");
    end

  // Transmit stays quiet through reset
  quietReset: assert property (@(posedge pClk) !rstN |-> !upTx.valid)
    else
    begin
      failCount++;
      $error("Transmit valid during reset");
    end

endmodule

bind portMux accelShell_props propsInst (.*);

`default_nettype wire

/* dv/accel_input.txt */
# op idx addrOrTag data expected, numbers in hex; write uses addr, read uses tag
# burst reads ports 0 to 3 with tags counting up from its third column
# Reset values
read      0 01 00000000 00000000
read      1 02 00000000 00000000
read      2 03 00000000 6A09E667
read      3 04 00000000 6A09E667
# Running sums, wrap past 2^32
write     0 00 00000010 00000000
write     0 00 FFFFFFF8 00000000
write     1 00 12345678 00000000
read      0 10 00000000 00000008
read      1 11 00000000 12345678
write     1 00 EDCBA989 00000000
write     0 00 00000100 00000000
read      0 12 00000000 00000108
read      1 13 00000000 00000001
# Fold-hash feeds and a reseed
write     2 00 11111111 00000000
write     3 00 FFFFFFFF 00000000
read      2 20 00000000 502DDDFC
read      3 21 00000000 BEC33312
write     2 00 0000000F 00000000
write     3 01 00000000 00000000
read      2 22 00000000 05BBBF85
read      3 23 00000000 6A09E667
write     3 00 6A09E667 00000000
read      3 24 00000000 2B352A8A
# Clear one sum
write     0 01 00000000 00000000
read      0 30 00000000 00000000
write     0 00 00000007 00000000
read      0 31 00000000 00000007
read      1 32 00000000 00000001
# All four ports back to back
burst     0 40 00000000 00000000
# Soft reset
softreset 0 00 00000000 00000000
read      0 50 00000000 00000000
read      1 51 00000000 00000000
read      2 52 00000000 6A09E667
read      3 53 00000000 6A09E667
burst     0 60 00000000 00000000

/* run.sh */
#!/bin/sh
# Compile with Verilator, run the testbench and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sources.f --top-module accelShellTb -o accelShellSim

./obj_dir/accelShellSim | tee sim.log

if grep -qx "No errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* sources.f */
+incdir+design
design/accelPkg.sv
design/portMux.sv
design/sumAccel.sv
design/foldHashAccel.sv
design/accelShell.sv
dv/accelShell_props.sv
dv/accelShellTb.sv
